//--- Makefile
TOP := tb_grad_top
BIN := obj_dir/V$(TOP)
SRC := $(filter-out +incdir+%,$(shell cat filelist.f)) tests/grad_model.svh

.PHONY: all run clean

all: run

$(BIN): filelist.f $(SRC)
	verilator --binary --timing -f filelist.f --top-module $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

//--- filelist.f
+incdir+tests
logic/grad_pkg.sv
logic/window_gen.sv
logic/sum_sq_diff.sv
logic/sqrt.sv
logic/div.sv
logic/mag_cal.sv
logic/grad_top.sv
tests/tb_grad_top.sv

//--- logic/div.sv
`timescale 1ns/100ps
`default_nettype none

module div (
    input  wire logic          clk,
    input  grad_pkg::diff_t    ver_diff,
    input  grad_pkg::diff_t    hor_diff,
    output grad_pkg::tan_t     tan
);

    // half_w quotient bits, then the remainder in the low bits
    function automatic logic [grad_pkg::half_w+grad_pkg::pix_w-1:0] long_div(
        input logic [grad_pkg::pix_w-1:0]  rem_in,
        input logic [grad_pkg::half_w-1:0] num_bits,
        input logic [grad_pkg::pix_w-1:0]  dsr
    );
        logic [grad_pkg::pix_w:0]    part;
        logic [grad_pkg::pix_w-1:0]  rem;
        logic [grad_pkg::half_w-1:0] quo;
        rem = rem_in;
        quo = '0;
        for (int i = grad_pkg::half_w - 1; i >= 0; i--) begin
            part = {rem, num_bits[i]};
            if (part >= {1'b0, dsr}) begin
                part   = part - {1'b0, dsr};
                quo[i] = 1'b1;
            end
            rem = part[grad_pkg::pix_w-1:0];
        end
        return {quo, rem};
    endfunction

    grad_pkg::diff_t             ver_abs;
    grad_pkg::diff_t             hor_abs;

    logic [grad_pkg::pix_w-1:0]  s1_num;
    logic [grad_pkg::pix_w-1:0]  s1_dsr;
    logic                        s1_neg;
    logic                        s1_ver_zero;
    logic                        s1_hor_zero;

    logic [grad_pkg::half_w+grad_pkg::pix_w-1:0] hi_res;
    logic [grad_pkg::half_w+grad_pkg::pix_w-1:0] lo_res;
    logic [grad_pkg::half_w-1:0] s2_quo_hi;
    logic [grad_pkg::pix_w-1:0]  s2_rem;
    logic [grad_pkg::pix_w-1:0]  s2_dsr;
    logic                        s2_neg;
    logic                        s2_ver_zero;
    logic                        s2_hor_zero;

    logic [grad_pkg::quo_w-1:0]  quo;
    logic                        ovf;
    grad_pkg::tan_t              quo_tan;

    // |diff| <= 255, so the magnitudes drop to pix_w bits
    assign ver_abs = ver_diff[grad_pkg::pix_w] ? -ver_diff : ver_diff;
    assign hor_abs = hor_diff[grad_pkg::pix_w] ? -hor_diff : hor_diff;

    always_ff @(posedge clk) begin
        s1_num      <= ver_abs[grad_pkg::pix_w-1:0];
        s1_dsr      <= hor_abs[grad_pkg::pix_w-1:0];
        s1_neg      <= ver_diff[grad_pkg::pix_w] ^ hor_diff[grad_pkg::pix_w];
        s1_ver_zero <= (ver_diff == '0);
        s1_hor_zero <= (hor_diff == '0);
    end

    // upper half of the dividend is |ver| followed by zeros
    assign hi_res = long_div('0, {s1_num, {(grad_pkg::half_w - grad_pkg::pix_w){1'b0}}},
                             s1_dsr);

    always_ff @(posedge clk) begin
        s2_quo_hi   <= hi_res[grad_pkg::half_w+grad_pkg::pix_w-1 -: grad_pkg::half_w];
        s2_rem      <= hi_res[grad_pkg::pix_w-1:0];
        s2_dsr      <= s1_dsr;
        s2_neg      <= s1_neg;
        s2_ver_zero <= s1_ver_zero;
        s2_hor_zero <= s1_hor_zero;
    end

    assign lo_res  = long_div(s2_rem, '0, s2_dsr);
    assign quo     = {s2_quo_hi, lo_res[grad_pkg::half_w+grad_pkg::pix_w-1 -: grad_pkg::half_w]};
    assign ovf     = |quo[grad_pkg::quo_w-1:grad_pkg::tan_w-1];  // 2^19 or more
    assign quo_tan = {1'b0, quo[grad_pkg::tan_w-2:0]};

    always_ff @(posedge clk) begin
        if (s2_ver_zero)
            tan <= '0;
        else if (s2_hor_zero || ovf)
            tan <= s2_neg ? grad_pkg::tan_min : grad_pkg::tan_max;
        else if (s2_neg)
            tan <= -quo_tan;
        else
            tan <= quo_tan;
    end

endmodule

`default_nettype wire

//--- logic/grad_pkg.sv
`default_nettype none

package grad_pkg;

    localparam int pix_w = 8;
    localparam int mag_f = 4;                  // magnitude fraction bits
    localparam int mag_w = pix_w + 1 + mag_f;  // 9 integer bits
    localparam int tan_i = 4;                  // includes sign
    localparam int tan_f = 16;
    localparam int tan_w = tan_i + tan_f;

    localparam int img_w = 16;
    localparam int row_w = 8;
    localparam int col_w = 4;
    localparam logic [col_w-1:0] last_col = col_w'(img_w - 1);

    // pipeline latencies in cycles
    localparam int diff_lat = 1;
    localparam int sum_lat  = 3;
    localparam int root_lat = 13;
    localparam int div_lat  = 3;
    localparam int calc_lat = sum_lat + root_lat;
    localparam int top_lat  = calc_lat + 1;   // plus window register
    localparam int tan_dly  = calc_lat - diff_lat - div_lat;

    localparam int rad_w  = 2 * root_lat;     // radicand as whole bit pairs
    localparam int rem_w  = mag_w + 3;        // sqrt partial remainder
    localparam int quo_w  = pix_w + tan_f;    // unsigned tangent quotient
    localparam int half_w = quo_w / 2;        // quotient bits per divide stage

    typedef logic [pix_w-1:0]        pixel_t;
    typedef logic signed [pix_w:0]   diff_t;
    typedef logic [2*pix_w:0]        sum_sq_t;
    typedef logic [mag_w-1:0]        mag_t;
    typedef logic signed [tan_w-1:0] tan_t;

    localparam tan_t tan_max = {1'b0, {(tan_w - 1){1'b1}}};
    localparam tan_t tan_min = {1'b1, {(tan_w - 1){1'b0}}};

    typedef struct packed {
        pixel_t top;
        pixel_t bot;
        pixel_t left;
        pixel_t right;
    } quad_pix_t;

    typedef struct packed {
        mag_t magnitude;
        tan_t tan;
    } grad_t;

endpackage

`default_nettype wire

//--- logic/grad_top.sv
`timescale 1ns/100ps
`default_nettype none

module grad_top (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           in_valid,
    input  wire logic           sof,
    input  grad_pkg::pixel_t    pixel,
    output logic                out_valid,
    output grad_pkg::grad_t     grad
);

    logic                quad_valid;
    grad_pkg::quad_pix_t quad;

    window_gen u_window_gen (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .sof        (sof),
        .pixel      (pixel),
        .quad_valid (quad_valid),
        .quad       (quad)
    );

    // cross to result in calc_lat cycles
    mag_cal u_mag_cal (
        .clk        (clk),
        .rst        (rst),
        .quad_valid (quad_valid),
        .quad       (quad),
        .out_valid  (out_valid),
        .grad       (grad)
    );

endmodule

`default_nettype wire

//--- logic/mag_cal.sv
`timescale 1ns/100ps
`default_nettype none

module mag_cal (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              quad_valid,
    input  grad_pkg::quad_pix_t    quad,
    output logic                   out_valid,
    output grad_pkg::grad_t        grad
);

    grad_pkg::diff_t   ver_diff;
    grad_pkg::diff_t   hor_diff;
    grad_pkg::sum_sq_t sum_sq;
    grad_pkg::mag_t    magnitude;
    grad_pkg::tan_t    tan_div;

    grad_pkg::tan_t               tan_q [grad_pkg::tan_dly];
    logic [grad_pkg::calc_lat-1:0] valid_q;

    // diffs after 1 cycle, sum of squares after 3
    sum_sq_diff u_sum_sq_diff (
        .clk      (clk),
        .quad     (quad),
        .ver_diff (ver_diff),
        .hor_diff (hor_diff),
        .sum_sq   (sum_sq)
    );

    sqrt u_sqrt (
        .clk       (clk),
        .sum_sq    (sum_sq),
        .magnitude (magnitude)
    );

    // tan ready at cycle 4, magnitude at 16
    div u_div (
        .clk      (clk),
        .ver_diff (ver_diff),
        .hor_diff (hor_diff),
        .tan      (tan_div)
    );

    always_ff @(posedge clk) begin
        tan_q[0] <= tan_div;
        for (int i = 1; i < grad_pkg::tan_dly; i++)
            tan_q[i] <= tan_q[i-1];
    end

    always_ff @(posedge clk) begin
        if (!rst)
            valid_q <= '0;
        else
            valid_q <= {valid_q[grad_pkg::calc_lat-2:0], quad_valid};
    end

    assign out_valid      = valid_q[grad_pkg::calc_lat-1];
    assign grad.magnitude = magnitude;
    assign grad.tan       = tan_q[grad_pkg::tan_dly-1];

endmodule

`default_nettype wire

//--- logic/sqrt.sv
`timescale 1ns/100ps
`default_nettype none

module sqrt (
    input  wire logic            clk,
    input  grad_pkg::sum_sq_t    sum_sq,
    output grad_pkg::mag_t       magnitude
);

    // per-stage pipeline state
    logic [grad_pkg::rad_w-1:0] rad_q  [grad_pkg::root_lat];
    logic [grad_pkg::rem_w-1:0] rem_q  [grad_pkg::root_lat];
    grad_pkg::mag_t             root_q [grad_pkg::root_lat];

    for (genvar s = 0; s < grad_pkg::root_lat; s++) begin : g_stage
        logic [grad_pkg::rad_w-1:0] rad_prev;
        logic [grad_pkg::rem_w-1:0] rem_prev;
        logic [grad_pkg::rem_w-1:0] rem_cat;
        logic [grad_pkg::rem_w-1:0] trial;
        grad_pkg::mag_t             root_prev;

        if (s == 0) begin : g_first
            // scale by 2^(2*mag_f) for the fraction bits, pad to an even width
            assign rad_prev  = {1'b0, sum_sq, {(2 * grad_pkg::mag_f){1'b0}}};
            assign rem_prev  = '0;
            assign root_prev = '0;
        end else begin : g_next
            assign rad_prev  = rad_q[s-1];
            assign rem_prev  = rem_q[s-1];
            assign root_prev = root_q[s-1];
        end

        // bring down the next two radicand bits
        assign rem_cat = {rem_prev[grad_pkg::rem_w-3:0],
                          rad_prev[grad_pkg::rad_w-1 -: 2]};
        assign trial   = {1'b0, root_prev, 2'b01};  // 4*root + 1

        always_ff @(posedge clk) begin
            rad_q[s] <= rad_prev << 2;
            if (rem_cat >= trial) begin
                rem_q[s]  <= rem_cat - trial;
                root_q[s] <= {root_prev[grad_pkg::mag_w-2:0], 1'b1};
            end else begin
                rem_q[s]  <= rem_cat;  // restore
                root_q[s] <= {root_prev[grad_pkg::mag_w-2:0], 1'b0};
            end
        end
    end

    assign magnitude = root_q[grad_pkg::root_lat-1];

endmodule

`default_nettype wire

//--- logic/sum_sq_diff.sv
`timescale 1ns/100ps
`default_nettype none

module sum_sq_diff (
    input  wire logic              clk,
    input  grad_pkg::quad_pix_t    quad,
    output grad_pkg::diff_t        ver_diff,
    output grad_pkg::diff_t        hor_diff,
    output grad_pkg::sum_sq_t      sum_sq
);

    logic signed [2*grad_pkg::pix_w-1:0] ver_ext;
    logic signed [2*grad_pkg::pix_w-1:0] hor_ext;
    logic [2*grad_pkg::pix_w-1:0]        ver_sq;
    logic [2*grad_pkg::pix_w-1:0]        hor_sq;

    // stage 1, zero-extended pixels
    always_ff @(posedge clk) begin
        ver_diff <= $signed({1'b0, quad.bot}) - $signed({1'b0, quad.top});
        hor_diff <= $signed({1'b0, quad.right}) - $signed({1'b0, quad.left});
    end

    assign ver_ext = {{(grad_pkg::pix_w - 1){ver_diff[grad_pkg::pix_w]}}, ver_diff};
    assign hor_ext = {{(grad_pkg::pix_w - 1){hor_diff[grad_pkg::pix_w]}}, hor_diff};

    // stage 2, 255^2 still fits 16 bits
    always_ff @(posedge clk) begin
        ver_sq <= ver_ext * ver_ext;
        hor_sq <= hor_ext * hor_ext;
    end

    // stage 3
    always_ff @(posedge clk) begin
        sum_sq <= {1'b0, ver_sq} + {1'b0, hor_sq};
    end

endmodule

`default_nettype wire

//--- logic/window_gen.sv
`timescale 1ns/100ps
`default_nettype none

module window_gen (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 in_valid,
    input  wire logic                 sof,
    input  grad_pkg::pixel_t          pixel,
    output logic                      quad_valid,
    output grad_pkg::quad_pix_t       quad
);

    // two rows of history, roles swap at every row end
    grad_pkg::pixel_t line_mem [2][grad_pkg::img_w];
    logic                        wr_sel;     // buffer holding row r-2, overwritten by row r

    logic [grad_pkg::col_w-1:0]  col_cnt;
    logic [grad_pkg::row_w-1:0]  row_cnt;
    logic [grad_pkg::col_w-1:0]  cur_col;
    logic [grad_pkg::row_w-1:0]  cur_row;

    grad_pkg::pixel_t            mid_sr [2]; // middle row at c-1 and c-2
    grad_pkg::pixel_t            top_d;      // row r-2 at c-1
    grad_pkg::pixel_t            last_pix;   // current row at c-1
    grad_pkg::pixel_t            up_pix;
    grad_pkg::pixel_t            mid_pix;
    logic                        interior;

    // sof restarts the frame on the pixel that carries it
    assign cur_col = sof ? '0 : col_cnt;
    assign cur_row = sof ? '0 : row_cnt;

    assign up_pix   = line_mem[wr_sel][cur_col];
    assign mid_pix  = line_mem[!wr_sel][cur_col];
    assign interior = (cur_row >= 2) && (cur_col >= 2);

    always_ff @(posedge clk) begin
        if (!rst) begin
            col_cnt    <= '0;
            row_cnt    <= '0;
            wr_sel     <= 1'b0;
            quad_valid <= 1'b0;
        end else begin
            quad_valid <= in_valid && interior;
            if (in_valid) begin
                if (cur_col == grad_pkg::last_col) begin
                    col_cnt <= '0;
                    wr_sel  <= !wr_sel;
                    if (cur_row != '1)
                        row_cnt <= cur_row + 1'b1;
                    else
                        row_cnt <= cur_row;  // hold at max, only r >= 2 matters
                end else begin
                    col_cnt <= cur_col + 1'b1;
                    row_cnt <= cur_row;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            line_mem[wr_sel][cur_col] <= pixel;
            top_d     <= up_pix;
            mid_sr[0] <= mid_pix;
            mid_sr[1] <= mid_sr[0];
            last_pix  <= pixel;
            quad.top   <= top_d;
            quad.bot   <= last_pix;
            quad.left  <= mid_sr[1];
            quad.right <= mid_pix;
        end
    end

endmodule

`default_nettype wire

//--- tests/grad_model.svh
`ifndef GRAD_MODEL_SVH
`define GRAD_MODEL_SVH

// pixel history of the current frame by row and column
localparam int max_rows = 8;

typedef grad_pkg::pixel_t frame_t [max_rows][grad_pkg::img_w];

// cross around (r-1, c-1) that pixel (r, c) completes
function automatic grad_pkg::quad_pix_t cross_at(input frame_t f, input int r, input int c);
    grad_pkg::quad_pix_t q;
    q.top   = f[r-2][c-1];
    q.bot   = f[r][c-1];
    q.left  = f[r-1][c-2];
    q.right = f[r-1][c];
    return q;
endfunction

// largest root whose square does not exceed x
function automatic int floor_sqrt(input longint x);
    int root;
    int trial;
    root = 0;
    for (int b = 15; b >= 0; b--) begin
        trial = root | (1 << b);
        if (longint'(trial) * longint'(trial) <= x)
            root = trial;
    end
    return root;
endfunction

function automatic grad_pkg::tan_t sat_tan(input int v, input int h);
    longint lim;  // 2^(tan_w-1)
    longint q;
    logic   neg;
    lim = longint'(1) <<< (grad_pkg::tan_w - 1);
    neg = (v < 0) != (h < 0);
    if (v == 0)
        return '0;
    if (h == 0)
        return neg ? grad_pkg::tan_t'(-lim) : grad_pkg::tan_t'(lim - 1);
    q = (longint'(v < 0 ? -v : v) <<< grad_pkg::tan_f) / longint'(h < 0 ? -h : h);
    if (neg)
        q = -q;  // division above already truncated toward zero
    if (q >= lim)
        return grad_pkg::tan_t'(lim - 1);
    if (q < -lim)
        return grad_pkg::tan_t'(-lim);
    return grad_pkg::tan_t'(q);
endfunction

function automatic grad_pkg::grad_t expected_grad(input grad_pkg::quad_pix_t q);
    grad_pkg::grad_t g;
    int              v;
    int              h;
    longint          ss;
    v  = int'(q.bot) - int'(q.top);
    h  = int'(q.right) - int'(q.left);
    ss = longint'(v * v + h * h);
    g.magnitude = grad_pkg::mag_t'(floor_sqrt(ss <<< (2 * grad_pkg::mag_f)));
    g.tan       = sat_tan(v, h);
    return g;
endfunction

`endif

//--- tests/tb_grad_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_grad_top;

    `include "grad_model.svh"

    localparam int mode_rand = 0, mode_edge = 1, mode_flat = 2;
    localparam int gap_none = 0, gap_rand = 1, gap_long = 2;
    // at most one idle cycle per pixel in every frame but the latency one
    localparam int gapped_pix  = (6 + 4 + 6 + 4 + 3 + 4 + 3) * grad_pkg::img_w + 7;
    localparam int stim_cycles = 2 * gapped_pix + 3 * grad_pkg::img_w * (grad_pkg::top_lat + 3)
                                 + 7 * (grad_pkg::top_lat + 3) + 6;
    localparam int margin      = 100;

    logic                clk = 1'b0;
    logic                rst, in_valid, sof, out_valid;
    grad_pkg::pixel_t    pixel;
    grad_pkg::grad_t     grad;

    integer              seed;
    frame_t              img;
    int                  row, col;  // model position within the frame
    int                  cycle = 0;  // rising edges so far
    int                  errors = 0, n_results = 0, n_formula = 0;
    grad_pkg::grad_t     exp_q [$];
    string               name_q [$];
    int                  edge_q [$];
    grad_pkg::grad_t     exp_grad;
    string               exp_name;
    int                  exp_edge;

    grad_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .sof       (sof),
        .pixel     (pixel),
        .out_valid (out_valid),
        .grad      (grad)
    );

    always #50 clk = ~clk;

    task automatic apply_reset();
        rst      = 1'b0;
        in_valid = 1'b0;
        sof      = 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                errors++;
                $display("out_valid is not low while reset is held");
            end
        end
        rst = 1'b1;
        row = 0;
        col = 0;
    endtask

    task automatic idle_cycle();
        in_valid = 1'b0;
        sof      = 1'b0;
        pixel    = grad_pkg::pixel_t'($random(seed));  // random junk the DUT ignores
        @(negedge clk);
    endtask

    task automatic gen_pixel(input int mode, input int r, input int c,
                             output grad_pkg::pixel_t p);
        int rnd;
        rnd = $random(seed);
        if (mode == mode_edge && r < 4 && c < 6)
            p = (r >= 3 || c >= 3) ? 8'd255 : 8'd0;  // 255 against 0 on both axes
        else if (mode == mode_edge)
            p = (rnd[2:1] == 2'd0) ? 8'd0 : (rnd[2:1] == 2'd1) ? 8'd255 : rnd[15:8];
        else if (mode == mode_flat)
            p = (rnd[2:0] == 3'd0) ? rnd[15:8] : {6'b100000, rnd[4:3]};  // 128 to 131
        else
            p = rnd[15:8];
    endtask

    task automatic send_pixel(input grad_pkg::pixel_t p, input logic start, input string name);
        if (start) begin
            row = 0;
            col = 0;
        end
        img[row][col] = p;
        if (row >= 2 && col >= 2) begin
            exp_q.push_back(expected_grad(cross_at(img, row, col)));
            name_q.push_back(name);
            edge_q.push_back(cycle + 1 + grad_pkg::top_lat);  // accepted on next rising edge
        end
        in_valid = 1'b1;
        sof      = start;
        pixel    = p;
        @(negedge clk);
        in_valid = 1'b0;
        sof      = 1'b0;
        if (col == grad_pkg::img_w - 1) begin
            col = 0;
            row = row + 1;
        end else begin
            col = col + 1;
        end
    endtask

    task automatic send_frame(input string name, input int rows, input int extra,
                              input int mode, input int gap, input logic with_sof);
        grad_pkg::pixel_t p;
        int               npix;
        npix = rows * grad_pkg::img_w + extra;
        for (int i = 0; i < npix; i++) begin
            gen_pixel(mode, i / grad_pkg::img_w, i % grad_pkg::img_w, p);
            if (gap == gap_rand && ($random(seed) & 3) == 0)
                idle_cycle();
            send_pixel(p, with_sof && i == 0, name);
            if (gap == gap_long)
                repeat (grad_pkg::top_lat + 2) idle_cycle();  // isolated pixel
        end
        n_formula += (rows - 2) * (grad_pkg::img_w - 2) + ((extra > 2) ? extra - 2 : 0);
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);  // nothing stray may follow
    endtask

    // a consumer takes the outputs at this edge before the edge updates them
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (out_valid === 1'b1) begin
            n_results++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_valid high at edge %0d with no pixel cross behind it", cycle);
            end else begin
                exp_grad = exp_q.pop_front();
                exp_name = name_q.pop_front();
                exp_edge = edge_q.pop_front();
                if (grad.magnitude !== exp_grad.magnitude) begin
                    errors++;
                    $display("mismatch %s magnitude expected %0d actual %0d",
                             exp_name, exp_grad.magnitude, grad.magnitude);
                end
                if (grad.tan !== exp_grad.tan) begin
                    errors++;
                    $display("mismatch %s tan expected %0d actual %0d",
                             exp_name, $signed(exp_grad.tan), $signed(grad.tan));
                end
                if (cycle != exp_edge) begin
                    errors++;
                    $display("mismatch %s latency expected edge %0d actual edge %0d",
                             exp_name, exp_edge, cycle);
                end
            end
        end
    end

    initial begin
        seed     = 32'hed49;
        rst      = 1'b0;
        in_valid = 1'b0;
        sof      = 1'b0;
        pixel    = '0;
        apply_reset();
        send_frame("window", 6, 0, mode_rand, gap_rand, 1'b1);
        drain();
        send_frame("magnitude", 4, 0, mode_edge, gap_rand, 1'b1);
        drain();
        send_frame("tangent", 6, 0, mode_flat, gap_rand, 1'b1);
        drain();
        send_frame("latency", 3, 0, mode_rand, gap_long, 1'b1);
        drain();
        send_frame("burst", 4, 0, mode_rand, gap_none, 1'b1);
        drain();
        send_frame("restart", 3, 7, mode_rand, gap_rand, 1'b1);  // cut short mid-row
        send_frame("restart", 4, 0, mode_flat, gap_rand, 1'b1);
        drain();
        apply_reset();
        send_frame("reset", 3, 0, mode_rand, gap_none, 1'b0);  // counters start from reset without sof
        drain();
        if (n_results != n_formula) begin
            errors++;
            $display("mismatch count expected %0d actual %0d", n_formula, n_results);
        end
        $display("results %0d of %0d, errors %0d", n_results, n_formula, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        #((stim_cycles + grad_pkg::top_lat + margin) * 100);
        $display("watchdog expired at edge %0d before the sequence finished, errors %0d",
                 cycle, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
